/* Bender.yml */
package:
  name: mps

dependencies: {}

sources:
  # packages first, then the RTL in bottom-up order
  - hdl/mps_axi_pkg.sv
  - hdl/mps_uart_pkg.sv
  - hdl/mps_axi_slave.sv
  - hdl/mps_port.sv
  - hdl/mps_top.sv

  # testbench, top module mps_tb
  - target: test
    files:
      - tests/mps_assertions.sv
      - tests/mps_tb.sv

/* all.f */
hdl/mps_axi_pkg.sv
hdl/mps_uart_pkg.sv
hdl/mps_axi_slave.sv
hdl/mps_port.sv
hdl/mps_top.sv
tests/mps_assertions.sv
tests/mps_tb.sv

/* hdl/mps_axi_pkg.sv */
`default_nettype none

package mps_axi_pkg;

	// bus widths of the host register port
	localparam int AXI_ADDR_W = 32;
	localparam int AXI_DATA_W = 32;
	localparam int AXI_STRB_W = AXI_DATA_W / 8;

	// AXI response codes
	localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
	localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;   // partial write, bad offset, busy tx

endpackage

`default_nettype wire

/* hdl/mps_axi_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module mps_axi_slave import mps_axi_pkg::*; (
	input  logic                  core_clk,
	input  logic                  ext_rst,

	// write address and data
	input  logic                  awvalid_i,
	output logic                  awready_o,
	input  logic [AXI_ADDR_W-1:0] awaddr_i,
	input  logic                  wvalid_i,
	output logic                  wready_o,
	input  logic [AXI_DATA_W-1:0] wdata_i,
	input  logic [AXI_STRB_W-1:0] wstrb_i,

	// write response
	output logic                  bvalid_o,
	input  logic                  bready_i,
	output logic [1:0]            bresp_o,

	// read address
	input  logic                  arvalid_i,
	output logic                  arready_o,
	input  logic [AXI_ADDR_W-1:0] araddr_i,

	// read response
	output logic                  rvalid_o,
	input  logic                  rready_i,
	output logic [AXI_DATA_W-1:0] rdata_o,
	output logic [1:0]            rresp_o,

	// register strobe side
	output logic [AXI_ADDR_W-1:0] reg_addr_o,
	output logic [AXI_DATA_W-1:0] reg_wdata_o,
	output logic                  reg_wr_o,
	output logic                  reg_rd_o,
	input  logic [AXI_DATA_W-1:0] reg_rdata_i,
	input  logic                  reg_err_i
);

	logic aw_hs;    // AW and W accepted together
	logic ar_hs;
	logic wr_full;  // all byte lanes enabled

	// one read response outstanding at most
	assign arready_o = ~rvalid_o;
	assign ar_hs     = arvalid_i & arready_o;

	// the strobe path is shared, a read in the same cycle holds the write off
	assign aw_hs     = awvalid_i & wvalid_i & ~bvalid_o & ~ar_hs;
	assign awready_o = aw_hs;
	assign wready_o  = aw_hs;

	assign wr_full = &wstrb_i;

	assign reg_addr_o  = ar_hs ? araddr_i : awaddr_i;
	assign reg_wdata_o = wdata_i;
	assign reg_wr_o    = aw_hs & wr_full;   // partial writes never reach a channel
	assign reg_rd_o    = ar_hs;

	// write response, held until the master takes it
	always_ff @(posedge core_clk or posedge ext_rst) begin
		if (ext_rst) begin
			bvalid_o <= 1'b0;
			bresp_o  <= AXI_RESP_OKAY;
		end else if (aw_hs) begin
			bvalid_o <= 1'b1;
			if (!wr_full || reg_err_i)
				bresp_o <= AXI_RESP_SLVERR;
			else
				bresp_o <= AXI_RESP_OKAY;
		end else if (bready_i) begin
			bvalid_o <= 1'b0;
		end
	end

	// read response control
	always_ff @(posedge core_clk or posedge ext_rst) begin
		if (ext_rst) begin
			rvalid_o <= 1'b0;
			rresp_o  <= AXI_RESP_OKAY;
		end else if (ar_hs) begin
			rvalid_o <= 1'b1;
			rresp_o  <= reg_err_i ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
		end else if (rready_i) begin
			rvalid_o <= 1'b0;
		end
	end

	// read data captured once per handshake, stable while rvalid_o is up
	always_ff @(posedge core_clk) begin
		if (ar_hs)
			rdata_o <= reg_rdata_i;
	end

endmodule

`default_nettype wire

/* hdl/mps_port.sv */
`timescale 1ns/1ps
`default_nettype none

module mps_port import mps_uart_pkg::*; #(
	parameter logic [15:0] DEFAULT_DIV = 16'd868
) (
	input  logic                        core_clk,
	input  logic                        ext_rst,

	// register access
	input  logic                        sel_i,
	input  logic                        wr_i,
	input  logic                        rd_i,
	input  logic [CHAN_STRIDE_BITS-1:0] offset_i,
	input  mps_reg_word_u               wdata_i,
	output logic [31:0]                 rdata_o,
	output logic                        err_o,

	// serial line
	input  logic                        rxd_i,
	output logic                        txd_o,

	output logic                        irq_o
);

	logic [15:0] ctrl_div;
	logic        ctrl_en;
	logic        ctrl_irq_en;

	logic        wr_data;
	logic        wr_ctrl;
	logic        rd_data;
	logic        rd_stat;

	logic        tx_busy;
	logic        tx_start;
	logic        tx_tick;
	logic [15:0] tx_cnt;
	logic [3:0]  tx_bit;
	logic [8:0]  tx_shift;   // data bits then stop bit

	logic [1:0]  rx_sync;
	logic        rx_prev;
	logic        rx_busy;
	logic        rx_mid;
	logic        rx_tick;
	logic        rx_stop;
	logic        rx_load;
	logic [15:0] rx_cnt;
	logic [3:0]  rx_bit;
	logic [7:0]  rx_shift;
	logic [7:0]  rx_byte;
	logic        rx_valid;
	logic        overrun;
	logic        frame_err;

	assign wr_data = sel_i & wr_i & (offset_i == REG_DATA);
	assign wr_ctrl = sel_i & wr_i & (offset_i == REG_CTRL);
	assign rd_data = sel_i & rd_i & (offset_i == REG_DATA);
	assign rd_stat = sel_i & rd_i & (offset_i == REG_STATUS);

	// control register
	always_ff @(posedge core_clk or posedge ext_rst) begin
		if (ext_rst) begin
			ctrl_div    <= DEFAULT_DIV;
			ctrl_en     <= 1'b1;
			ctrl_irq_en <= 1'b0;
		end else if (wr_ctrl) begin
			ctrl_div    <= wdata_i.ctrl.divisor;
			ctrl_en     <= wdata_i.ctrl.enable;
			ctrl_irq_en <= wdata_i.ctrl.irq_en;
		end
	end

	// transmitter
	assign tx_start = wr_data & ~tx_busy & ctrl_en;   // busy write is dropped
	assign tx_tick  = tx_busy & (tx_cnt == ctrl_div - 16'd1);

	always_ff @(posedge core_clk or posedge ext_rst) begin
		if (ext_rst) begin
			tx_busy <= 1'b0;
			tx_cnt  <= '0;
			tx_bit  <= '0;
			txd_o   <= 1'b1;
		end else if (tx_start) begin
			tx_busy <= 1'b1;
			tx_cnt  <= '0;
			tx_bit  <= '0;
			txd_o   <= 1'b0;   // start bit
		end else if (tx_busy) begin
			tx_cnt <= tx_tick ? '0 : tx_cnt + 16'd1;
			if (tx_tick) begin
				txd_o <= tx_shift[0];
				if (tx_bit == 4'd9)
					tx_busy <= 1'b0;   // end of stop bit
				else
					tx_bit <= tx_bit + 4'd1;
			end
		end
	end

	always_ff @(posedge core_clk) begin
		if (tx_start)
			tx_shift <= {1'b1, wdata_i.data.tx_byte};
		else if (tx_tick)
			tx_shift <= {1'b1, tx_shift[8:1]};   // ones fill in behind
	end

	// receiver, sampled at mid bit
	assign rx_mid  = rx_busy & (rx_cnt == (ctrl_div >> 1));
	assign rx_tick = rx_busy & (rx_cnt == ctrl_div - 16'd1);
	assign rx_stop = rx_mid & (rx_bit == 4'd9);
	assign rx_load = rx_stop & rx_sync[1] & ~(rx_valid & ~rd_data);

	always_ff @(posedge core_clk or posedge ext_rst) begin
		if (ext_rst) begin
			rx_sync <= 2'b11;
			rx_prev <= 1'b1;
			rx_busy <= 1'b0;
			rx_cnt  <= '0;
			rx_bit  <= '0;
		end else begin
			rx_sync <= {rx_sync[0], rxd_i};
			rx_prev <= rx_sync[1];
			if (!rx_busy) begin
				if (ctrl_en && rx_prev && !rx_sync[1]) begin   // falling edge
					rx_busy <= 1'b1;
					rx_cnt  <= '0;
					rx_bit  <= '0;
				end
			end else begin
				rx_cnt <= rx_tick ? '0 : rx_cnt + 16'd1;
				if (rx_tick)
					rx_bit <= rx_bit + 4'd1;
				// a high start sample was a glitch
				if (rx_mid && ((rx_bit == 4'd0 && rx_sync[1]) || rx_bit == 4'd9))
					rx_busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge core_clk) begin
		if (rx_mid && rx_bit != 4'd0 && rx_bit != 4'd9)
			rx_shift <= {rx_sync[1], rx_shift[7:1]};   // lsb first
		if (rx_load)
			rx_byte <= rx_shift;
	end

	// holding register state and sticky flags
	always_ff @(posedge core_clk or posedge ext_rst) begin
		if (ext_rst) begin
			rx_valid  <= 1'b0;
			overrun   <= 1'b0;
			frame_err <= 1'b0;
		end else begin
			if (rd_data)
				rx_valid <= 1'b0;
			if (rd_stat) begin
				overrun   <= 1'b0;
				frame_err <= 1'b0;
			end
			if (rx_stop) begin
				if (!rx_sync[1])
					frame_err <= 1'b1;   // byte discarded
				else if (rx_valid && !rd_data)
					overrun <= 1'b1;     // old byte kept
				else
					rx_valid <= 1'b1;
			end
		end
	end

	// read mux and error
	always_comb begin
		rdata_o = '0;
		err_o   = 1'b0;
		case (offset_i)
			REG_DATA: begin
				rdata_o[7:0] = rx_valid ? rx_byte : 8'h00;
				err_o        = wr_i & tx_busy;
			end
			REG_STATUS: begin
				rdata_o[STAT_TX_BUSY]   = tx_busy;
				rdata_o[STAT_RX_VALID]  = rx_valid;
				rdata_o[STAT_OVERRUN]   = overrun;
				rdata_o[STAT_FRAME_ERR] = frame_err;
			end
			REG_CTRL: rdata_o = {ctrl_div, 14'h0, ctrl_irq_en, ctrl_en};
			default: err_o = 1'b1;   // unknown offset
		endcase
	end

	assign irq_o = rx_valid & ctrl_irq_en;

endmodule

`default_nettype wire

/* hdl/mps_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mps_top import mps_axi_pkg::*, mps_uart_pkg::*; #(
	parameter int          NUM_PORTS   = 4,
	parameter logic [15:0] DEFAULT_DIV = 16'd868
) (
	input  logic                  core_clk,
	input  logic                  ext_rst,

	input  logic                  awvalid_i,
	output logic                  awready_o,
	input  logic [AXI_ADDR_W-1:0] awaddr_i,
	input  logic                  wvalid_i,
	output logic                  wready_o,
	input  logic [AXI_DATA_W-1:0] wdata_i,
	input  logic [AXI_STRB_W-1:0] wstrb_i,
	output logic                  bvalid_o,
	input  logic                  bready_i,
	output logic [1:0]            bresp_o,
	input  logic                  arvalid_i,
	output logic                  arready_o,
	input  logic [AXI_ADDR_W-1:0] araddr_i,
	output logic                  rvalid_o,
	input  logic                  rready_i,
	output logic [AXI_DATA_W-1:0] rdata_o,
	output logic [1:0]            rresp_o,

	input  logic [NUM_PORTS-1:0]  rxd_i,
	output logic [NUM_PORTS-1:0]  txd_o,
	output logic                  irq_o
);

	localparam int IDX_W = AXI_ADDR_W - CHAN_STRIDE_BITS;

	logic [AXI_ADDR_W-1:0] reg_addr;
	logic [AXI_DATA_W-1:0] reg_wdata;
	logic                  reg_wr;
	logic                  reg_rd;
	logic [AXI_DATA_W-1:0] reg_rdata;
	logic                  reg_err;

	logic [IDX_W-1:0]            chan_idx;
	logic [CHAN_STRIDE_BITS-1:0] offset;
	logic                        in_range;

	logic [NUM_PORTS-1:0]                 port_sel;
	logic [NUM_PORTS-1:0][AXI_DATA_W-1:0] port_rdata;
	logic [NUM_PORTS-1:0]                 port_err;
	logic [NUM_PORTS-1:0]                 port_irq;

	mps_axi_slave u_axi (
		.core_clk(core_clk),
		.ext_rst(ext_rst),
		.awvalid_i(awvalid_i),
		.awready_o(awready_o),
		.awaddr_i(awaddr_i),
		.wvalid_i(wvalid_i),
		.wready_o(wready_o),
		.wdata_i(wdata_i),
		.wstrb_i(wstrb_i),
		.bvalid_o(bvalid_o),
		.bready_i(bready_i),
		.bresp_o(bresp_o),
		.arvalid_i(arvalid_i),
		.arready_o(arready_o),
		.araddr_i(araddr_i),
		.rvalid_o(rvalid_o),
		.rready_i(rready_i),
		.rdata_o(rdata_o),
		.rresp_o(rresp_o),
		.reg_addr_o(reg_addr),
		.reg_wdata_o(reg_wdata),
		.reg_wr_o(reg_wr),
		.reg_rd_o(reg_rd),
		.reg_rdata_i(reg_rdata),
		.reg_err_i(reg_err)
	);

	// channel index above the window, offset inside it
	assign chan_idx = reg_addr[AXI_ADDR_W-1:CHAN_STRIDE_BITS];
	assign offset   = reg_addr[CHAN_STRIDE_BITS-1:0];
	assign in_range = chan_idx < IDX_W'(NUM_PORTS);

	for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
		assign port_sel[i] = in_range & (chan_idx == IDX_W'(i));

		mps_port #(
			.DEFAULT_DIV(DEFAULT_DIV)
		) u_port (
			.core_clk(core_clk),
			.ext_rst(ext_rst),
			.sel_i(port_sel[i]),
			.wr_i(reg_wr),
			.rd_i(reg_rd),
			.offset_i(offset),
			.wdata_i(reg_wdata),
			.rdata_o(port_rdata[i]),
			.err_o(port_err[i]),
			.rxd_i(rxd_i[i]),
			.txd_o(txd_o[i]),
			.irq_o(port_irq[i])
		);
	end

	// out of range gives SLVERR and zero data
	always_comb begin
		reg_rdata = '0;
		reg_err   = ~in_range;
		for (int i = 0; i < NUM_PORTS; i++) begin
			if (port_sel[i]) begin
				reg_rdata = port_rdata[i];
				reg_err   = port_err[i];
			end
		end
	end

	assign irq_o = |port_irq;   // one request for all channels

endmodule

`default_nettype wire

/* hdl/mps_uart_pkg.sv */
`default_nettype none

package mps_uart_pkg;

	// each channel owns a 16 byte window
	localparam int CHAN_STRIDE_BITS = 4;

	// register offsets inside a channel window
	localparam logic [CHAN_STRIDE_BITS-1:0] REG_DATA   = 4'h0;   // tx on write, rx pop on read
	localparam logic [CHAN_STRIDE_BITS-1:0] REG_STATUS = 4'h4;   // read clears sticky flags
	localparam logic [CHAN_STRIDE_BITS-1:0] REG_CTRL   = 4'h8;

	// status word bit positions
	localparam int STAT_TX_BUSY   = 0;
	localparam int STAT_RX_VALID  = 1;
	localparam int STAT_OVERRUN   = 2;
	localparam int STAT_FRAME_ERR = 3;

	// one register word, seen as a tx byte or as the control word
	typedef union packed {
		struct packed {
			logic [23:0] rsvd;
			logic [7:0]  tx_byte;
		} data;
		struct packed {
			logic [15:0] divisor;   // bit period in core_clk cycles
			logic [13:0] rsvd;
			logic        irq_en;
			logic        enable;
		} ctrl;
	} mps_reg_word_u;

endpackage

`default_nettype wire

/* tests/mps_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module mps_assertions (
	input logic        core_clk,
	input logic        ext_rst,
	input logic        awready_i,
	input logic        wvalid_i,
	input logic        wready_i,
	input logic        bvalid_i,
	input logic        bready_i,
	input logic [1:0]  bresp_i,
	input logic        rvalid_i,
	input logic        rready_i,
	input logic [31:0] rdata_i,
	input logic [1:0]  rresp_i,
	input logic        reg_wr_i
);

	int unsigned fail_cnt = 0;   // summed into the run result

	a_b_hold: assert property (@(posedge core_clk) disable iff (ext_rst)
		bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
		else begin
			fail_cnt++;
			$error("write response dropped or changed before bready");
		end

	a_r_hold: assert property (@(posedge core_clk) disable iff (ext_rst)
		rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rresp_i))
		else begin
			fail_cnt++;
			$error("read response dropped or changed before rready");
		end

	// one write response outstanding
	a_aw_block: assert property (@(posedge core_clk) disable iff (ext_rst)
		!(awready_i && bvalid_i))
		else begin
			fail_cnt++;
			$error("awready raised while a write response is pending");
		end

	a_wr_strobe: assert property (@(posedge core_clk) disable iff (ext_rst)
		reg_wr_i |-> wvalid_i && wready_i)
		else begin
			fail_cnt++;
			$error("register write strobe without a W handshake");
		end

endmodule

bind mps_axi_slave mps_assertions u_sva (
	.core_clk(core_clk),
	.ext_rst(ext_rst),
	.awready_i(awready_o),
	.wvalid_i(wvalid_i),
	.wready_i(wready_o),
	.bvalid_i(bvalid_o),
	.bready_i(bready_i),
	.bresp_i(bresp_o),
	.rvalid_i(rvalid_o),
	.rready_i(rready_i),
	.rdata_i(rdata_o),
	.rresp_i(rresp_o),
	.reg_wr_i(reg_wr_o)
);

`default_nettype wire

/* tests/mps_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mps_tb
	import mps_axi_pkg::*, mps_uart_pkg::*;
();

	localparam int          NUM_PORTS      = 4;
	localparam logic [15:0] DIV            = 16'd8;
	localparam int          NUM_FRAMES     = 12;
	localparam int          TIMEOUT_CYCLES = NUM_FRAMES * 10 * DIV * 2 + 2000;

	logic                  core_clk;
	logic                  ext_rst;
	logic                  awvalid;
	logic                  awready;
	logic [AXI_ADDR_W-1:0] awaddr;
	logic                  wvalid;
	logic                  wready;
	logic [AXI_DATA_W-1:0] wdata;
	logic [AXI_STRB_W-1:0] wstrb;
	logic                  bvalid;
	logic                  bready;
	logic [1:0]            bresp;
	logic                  arvalid;
	logic                  arready;
	logic [AXI_ADDR_W-1:0] araddr;
	logic                  rvalid;
	logic                  rready;
	logic [AXI_DATA_W-1:0] rdata;
	logic [1:0]            rresp;
	logic [NUM_PORTS-1:0]  rxd;
	logic [NUM_PORTS-1:0]  txd;
	logic                  irq;

	logic   manual;    // channel 3 rx from man_rxd instead of txd[2]
	logic   man_rxd;
	integer seed;
	int     checks;
	int     errors;
	int     cycle_cnt;

	// per channel reference state
	logic       m_busy   [NUM_PORTS];
	logic       m_valid  [NUM_PORTS];
	logic       m_ovr    [NUM_PORTS];
	logic       m_ferr   [NUM_PORTS];
	logic       m_irq_en [NUM_PORTS];
	logic [7:0] m_byte   [NUM_PORTS];
	logic [7:0] m_pend   [NUM_PORTS];   // byte on the wire

	mps_top #(
		.NUM_PORTS(NUM_PORTS),
		.DEFAULT_DIV(DIV)
	) u_dut (
		.core_clk(core_clk),
		.ext_rst(ext_rst),
		.awvalid_i(awvalid),
		.awready_o(awready),
		.awaddr_i(awaddr),
		.wvalid_i(wvalid),
		.wready_o(wready),
		.wdata_i(wdata),
		.wstrb_i(wstrb),
		.bvalid_o(bvalid),
		.bready_i(bready),
		.bresp_o(bresp),
		.arvalid_i(arvalid),
		.arready_o(arready),
		.araddr_i(araddr),
		.rvalid_o(rvalid),
		.rready_i(rready),
		.rdata_o(rdata),
		.rresp_o(rresp),
		.rxd_i(rxd),
		.txd_o(txd),
		.irq_o(irq)
	);

	// board loopback, 0 with 1 and 2 with 3
	assign rxd[0] = txd[1];
	assign rxd[1] = txd[0];
	assign rxd[2] = txd[3];
	assign rxd[3] = manual ? man_rxd : txd[2];

	initial core_clk = 1'b0;
	always #50 core_clk = ~core_clk;

	function automatic logic [31:0] chan_addr(input int ch, input logic [3:0] off);
		return (32'(ch) << CHAN_STRIDE_BITS) | 32'(off);
	endfunction

	function automatic logic [31:0] ctrl_word(input logic [15:0] div, input logic irq_en);
		return {div, 14'h0, irq_en, 1'b1};
	endfunction

	function automatic logic [31:0] expect_status(input int ch);
		logic [31:0] st;
		st = '0;
		st[STAT_TX_BUSY]   = m_busy[ch];
		st[STAT_RX_VALID]  = m_valid[ch];
		st[STAT_OVERRUN]   = m_ovr[ch];
		st[STAT_FRAME_ERR] = m_ferr[ch];
		return st;
	endfunction

	function automatic logic [1:0] expect_resp(input logic [31:0] addr, input logic is_wr,
			input logic [3:0] strb, input logic busy);
		logic [3:0] off;
		off = addr[CHAN_STRIDE_BITS-1:0];
		if ((addr >> CHAN_STRIDE_BITS) >= NUM_PORTS)
			return AXI_RESP_SLVERR;
		if (off != REG_DATA && off != REG_STATUS && off != REG_CTRL)
			return AXI_RESP_SLVERR;
		if (is_wr && strb != 4'hf)
			return AXI_RESP_SLVERR;   // no partial writes
		if (is_wr && off == REG_DATA && busy)
			return AXI_RESP_SLVERR;
		return AXI_RESP_OKAY;
	endfunction

	function automatic logic expect_irq();
		logic any;
		any = 1'b0;
		for (int i = 0; i < NUM_PORTS; i++)
			any |= m_valid[i] & m_irq_en[i];
		return any;
	endfunction

	task automatic check_val(input string name, input logic [31:0] got,
			input logic [31:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("mismatch %s got %h exp %h", name, got, want);
		end
	endtask

	task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output logic [1:0] resp);
		@(negedge core_clk);
		awvalid = 1'b1;
		awaddr  = addr;
		wvalid  = 1'b1;
		wdata   = data;
		wstrb   = strb;
		#1;   // ready follows valid combinationally
		check_val("awready_o", awready, 1'b1);
		check_val("wready_o", wready, 1'b1);
		do @(negedge core_clk); while (!bvalid);
		check_val("awready_o", awready, 1'b0);   // held off while bvalid is up
		check_val("wready_o", wready, 1'b0);
		awvalid = 1'b0;   // pending bvalid blocks a second handshake
		wvalid  = 1'b0;
		resp    = bresp;
		@(negedge core_clk);
		bready = 1'b1;
		@(negedge core_clk);
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		@(negedge core_clk);
		check_val("arready_o", arready, 1'b1);
		arvalid = 1'b1;
		araddr  = addr;
		do @(negedge core_clk); while (!rvalid);
		check_val("arready_o", arready, 1'b0);
		arvalid = 1'b0;
		data    = rdata;
		resp    = rresp;
		@(negedge core_clk);   // response held one extra cycle
		rready = 1'b1;
		@(negedge core_clk);
		rready = 1'b0;
	endtask

	task automatic status_check(input int ch);
		logic [31:0] st;
		logic [1:0]  resp;
		axi_read(chan_addr(ch, REG_STATUS), st, resp);
		check_val("rresp", resp, AXI_RESP_OKAY);
		check_val("status", st, expect_status(ch));
		m_ovr[ch]  = 1'b0;   // read clears the sticky flags
		m_ferr[ch] = 1'b0;
	endtask

	task automatic poll_status(input int ch, input int pos, input logic want);
		logic [31:0] st;
		logic [1:0]  resp;
		do begin
			axi_read(chan_addr(ch, REG_STATUS), st, resp);
			m_ovr[ch]  = 1'b0;
			m_ferr[ch] = 1'b0;
		end while (st[pos] !== want);
	endtask

	task automatic set_ctrl(input int ch, input logic irq_en);
		logic [1:0] resp;
		axi_write(chan_addr(ch, REG_CTRL), ctrl_word(DIV, irq_en), 4'hf, resp);
		check_val("bresp", resp, AXI_RESP_OKAY);
		m_irq_en[ch] = irq_en;
	endtask

	task automatic send_byte(input int ch, input logic [7:0] b);
		logic [1:0] resp;
		logic [1:0] want;
		want = expect_resp(chan_addr(ch, REG_DATA), 1'b1, 4'hf, m_busy[ch]);
		axi_write(chan_addr(ch, REG_DATA), {24'h0, b}, 4'hf, resp);
		check_val("bresp", resp, want);
		if (want == AXI_RESP_OKAY) begin
			m_busy[ch] = 1'b1;
			m_pend[ch] = b;
		end
	endtask

	// sender idle, then the partner has sampled the stop bit
	task automatic finish_tx(input int ch);
		int dst;
		dst = ch ^ 1;
		poll_status(ch, STAT_TX_BUSY, 1'b0);
		m_busy[ch] = 1'b0;
		repeat (DIV) @(negedge core_clk);   // mid stop bit plus sync
		if (m_valid[dst]) begin
			m_ovr[dst] = 1'b1;
		end else begin
			m_valid[dst] = 1'b1;
			m_byte[dst]  = m_pend[ch];
		end
	endtask

	task automatic pop_check(input int ch);
		logic [31:0] data;
		logic [1:0]  resp;
		axi_read(chan_addr(ch, REG_DATA), data, resp);
		check_val("rresp", resp, AXI_RESP_OKAY);
		check_val("rx data", data, m_valid[ch] ? {24'h0, m_byte[ch]} : 32'h0);
		m_valid[ch] = 1'b0;
	endtask

	task automatic drive_frame(input logic [7:0] b, input logic stop_bit);
		logic [9:0] bits;
		bits = {stop_bit, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(negedge core_clk);
			man_rxd = bits[i];
			repeat (DIV - 1) @(negedge core_clk);
		end
		@(negedge core_clk);
		man_rxd = 1'b1;
		repeat (2 * DIV) @(negedge core_clk);
	endtask

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge core_clk);
			cycle_cnt++;
		end
		$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TB FAILED");
		$finish;
	end

	initial begin
		logic [31:0] rd;
		logic [1:0]  resp;
		logic [31:0] word;
		logic [7:0]  b0;
		logic [7:0]  b1;
		seed    = 32'he3a5_53c8;
		checks  = 0;
		errors  = 0;
		ext_rst = 1'b1;
		awvalid = 1'b0;
		awaddr  = '0;
		wvalid  = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		bready  = 1'b0;
		arvalid = 1'b0;
		araddr  = '0;
		rready  = 1'b0;
		manual  = 1'b0;
		man_rxd = 1'b1;
		for (int i = 0; i < NUM_PORTS; i++) begin
			m_busy[i]   = 1'b0;
			m_valid[i]  = 1'b0;
			m_ovr[i]    = 1'b0;
			m_ferr[i]   = 1'b0;
			m_irq_en[i] = 1'b0;
			m_byte[i]   = 8'h00;
			m_pend[i]   = 8'h00;
		end
		repeat (4) @(negedge core_clk);
		ext_rst = 1'b0;

		// reset state
		check_val("irq_o", irq, 1'b0);
		check_val("txd_o", txd, 4'hf);
		check_val("arready_o", arready, 1'b1);
		check_val("awready_o", awready, 1'b0);
		check_val("wready_o", wready, 1'b0);
		check_val("bvalid_o", bvalid, 1'b0);
		check_val("rvalid_o", rvalid, 1'b0);
		for (int ch = 0; ch < NUM_PORTS; ch++) begin
			status_check(ch);
			axi_read(chan_addr(ch, REG_CTRL), rd, resp);
			check_val("ctrl", rd, ctrl_word(DIV, 1'b0));
		end

		// control readback with random divisors
		for (int ch = 0; ch < NUM_PORTS; ch++) begin
			word = ctrl_word($random(seed), $random(seed));
			axi_write(chan_addr(ch, REG_CTRL), word, 4'hf, resp);
			check_val("bresp", resp, expect_resp(chan_addr(ch, REG_CTRL), 1'b1, 4'hf, 1'b0));
			axi_read(chan_addr(ch, REG_CTRL), rd, resp);
			check_val("rresp", resp, AXI_RESP_OKAY);
			check_val("ctrl", rd, word);
			set_ctrl(ch, 1'b0);
		end

		// loopback data on every channel
		for (int ch = 0; ch < NUM_PORTS; ch++) begin
			b0 = $random(seed);
			send_byte(ch, b0);
			status_check(ch);   // sender shows tx busy
			finish_tx(ch);
			poll_status(ch ^ 1, STAT_RX_VALID, 1'b1);
			status_check(ch ^ 1);
			pop_check(ch ^ 1);
			status_check(ch ^ 1);
		end

		// interrupt follows the held byte only with irq_en
		set_ctrl(1, 1'b1);
		send_byte(0, $random(seed));
		finish_tx(0);
		poll_status(1, STAT_RX_VALID, 1'b1);
		check_val("irq_o", irq, expect_irq());
		pop_check(1);
		check_val("irq_o", irq, expect_irq());
		set_ctrl(1, 1'b0);
		send_byte(1, $random(seed));
		finish_tx(1);
		poll_status(0, STAT_RX_VALID, 1'b1);
		check_val("irq_o", irq, expect_irq());
		pop_check(0);

		// bad offset, bad channel, partial write
		axi_read(chan_addr(0, 4'hc), rd, resp);
		check_val("rresp", resp, expect_resp(chan_addr(0, 4'hc), 1'b0, 4'hf, 1'b0));
		check_val("rdata", rd, 32'h0);
		axi_read(chan_addr(4, REG_STATUS), rd, resp);
		check_val("rresp", resp, expect_resp(chan_addr(4, REG_STATUS), 1'b0, 4'hf, 1'b0));
		check_val("rdata", rd, 32'h0);
		axi_write(chan_addr(4, REG_CTRL), ctrl_word(16'h55, 1'b1), 4'hf, resp);
		check_val("bresp", resp, expect_resp(chan_addr(4, REG_CTRL), 1'b1, 4'hf, 1'b0));
		axi_write(chan_addr(2, REG_CTRL), ctrl_word(16'h77, 1'b1), 4'h3, resp);
		check_val("bresp", resp, expect_resp(chan_addr(2, REG_CTRL), 1'b1, 4'h3, 1'b0));
		axi_read(chan_addr(2, REG_CTRL), rd, resp);
		check_val("ctrl", rd, ctrl_word(DIV, 1'b0));

		// second byte while busy is dropped
		b0 = $random(seed);
		b1 = $random(seed);
		send_byte(0, b0);
		send_byte(0, b1);
		finish_tx(0);
		status_check(1);
		pop_check(1);
		repeat (10 * DIV) @(negedge core_clk);   // a dropped byte would land here
		status_check(1);

		// overrun keeps the first byte
		b0 = $random(seed);
		send_byte(2, b0);
		finish_tx(2);
		poll_status(3, STAT_RX_VALID, 1'b1);
		send_byte(2, $random(seed));
		finish_tx(2);
		status_check(3);
		status_check(3);
		pop_check(3);
		status_check(3);

		// zero stop bit on a hand driven frame
		@(negedge core_clk);
		manual = 1'b1;
		drive_frame($random(seed), 1'b0);
		m_ferr[3] = 1'b1;
		status_check(3);
		status_check(3);
		manual = 1'b0;
		check_val("irq_o", irq, expect_irq());
		check_val("txd_o", txd, 4'hf);

		$display("mps_tb done: %0d checks, %0d errors, %0d assertion failures",
			checks, errors, u_dut.u_axi.u_sva.fail_cnt);
		if (errors == 0 && u_dut.u_axi.u_sva.fail_cnt == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire
